// File: sim.f
design/lsu_pkg.sv
design/lsu_store_align.sv
design/lsu_load_extract.sv
design/lsu_axi_master.sv
design/lsu_stage.sv
tests/lsu_asserts.sv
tests/lsu_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = lsu_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int MAX_OPS         = 80;  // upper bound on accesses over all tests
    localparam int OP_CYCLES       = 12;  // slowest access with every channel at its longest delay
    localparam int WATCHDOG_CYCLES = 2 * MAX_OPS * OP_CYCLES + 80;

    logic      clk = 1'b0;
    logic      rst;
    logic      ex_valid, ex_ready, wb_valid, wb_ready;
    lsu_req_t  ex_req;
    lsu_wb_t   wb;
    reg_addr_t fwd_rd;
    logic      fwd_reg_write, fwd_is_load;
    logic      ar_valid, ar_ready, r_valid, r_ready;
    logic      aw_valid, aw_ready, w_valid, w_ready, b_valid;
    axi_ar_t   ar;
    axi_aw_t   aw;
    axi_w_t    w;
    xlen_t     r_data;

    xlen_t     mem [0:255];      // slave memory
    xlen_t     ref_mem [0:255];  // expected contents
    strb_t     last_strb;        // strobe of the last write applied by the slave
    axi_size_t ar_size_seen;     // size of the last accepted read address
    axi_size_t aw_size_seen;     // size of the last accepted write address
    integer    seed = 65660;
    int        n_errors = 0;
    int        n_checks = 0;

    always #50 clk = ~clk;

    lsu_stage i_dut (.*);

    function automatic xlen_t fill_word(input int i);
        logic [7:0] a;
        a = i[7:0];
        return {a, ~a, 8'h3c, a ^ 8'hc3};
    endfunction

    function automatic logic [1:0] rand_delay();
        integer r;
        r = $random(seed);
        return r[1:0];
    endfunction

    // true once the channel delay has run out
    function automatic logic expired(inout logic [1:0] cnt);
        if (cnt == 2'd0) begin
            cnt = rand_delay();
            return 1'b1;
        end
        cnt = cnt - 2'd1;
        return 1'b0;
    endfunction

    function automatic int op_bytes(input mem_op_t op);
        case (op)
            MEM_B, MEM_BU: return 1;
            MEM_H, MEM_HU: return 2;
            default:       return 4;
        endcase
    endfunction

    // axsize is log2 of the bytes moved
    function automatic axi_size_t size_code(input mem_op_t op);
        case (op_bytes(op))
            1:       return AXI_SIZE_BYTE;
            2:       return AXI_SIZE_HALF;
            default: return AXI_SIZE_WORD;
        endcase
    endfunction

    // one bit per byte lane covered by the access
    function automatic strb_t lane_strobe(input mem_op_t op, input xlen_t addr);
        strb_t s;
        int    off;
        off = int'(addr[1:0]);
        for (int b = 0; b < 4; b++) begin
            s[b] = (b >= off) && (b < off + op_bytes(op));
        end
        return s;
    endfunction

    function automatic void apply_store(input mem_op_t op, input xlen_t addr, input xlen_t data);
        int off;
        off = int'(addr[1:0]);
        for (int k = 0; k < op_bytes(op); k++) begin
            ref_mem[addr[9:2]][8*(off+k) +: 8] = data[8*k +: 8];
        end
    endfunction

    function automatic xlen_t load_value(input mem_op_t op, input xlen_t addr);
        xlen_t word;
        xlen_t val;
        int    off;
        int    n;
        word = ref_mem[addr[9:2]];
        off  = int'(addr[1:0]);
        n    = op_bytes(op);
        val  = '0;
        for (int k = 0; k < n; k++) begin
            val[8*k +: 8] = word[8*(off+k) +: 8];
        end
        if (op == MEM_B || op == MEM_H) begin
            for (int k = n * 8; k < 32; k++) begin
                val[k] = val[n*8-1];
            end
        end
        return val;
    endfunction

    function automatic lsu_req_t mem_req(input logic is_load, input mem_op_t op,
                                         input reg_addr_t rd, input xlen_t addr,
                                         input xlen_t data);
        lsu_req_t r;
        r            = '0;
        r.mem_read   = is_load;
        r.mem_write  = !is_load;
        r.mem_op     = op;
        r.reg_write  = is_load;
        r.rd         = rd;
        r.addr       = addr;
        r.store_data = data;
        r.result     = 32'hffff_ffff; // must not reach wb for memory ops
        return r;
    endfunction

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_rd(input string name, input reg_addr_t got, input reg_addr_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_strb(input string name, input strb_t got, input strb_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_size(input string name, input axi_size_t got, input axi_size_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // returns just after the accept edge
    task automatic send(input lsu_req_t req);
        @(posedge clk);
        #1;
        ex_valid = 1'b1;
        ex_req   = req;
        @(negedge clk);
        while (!ex_ready) @(negedge clk);
        @(posedge clk);
        #1;
        ex_valid = 1'b0;
    endtask

    task automatic collect(output lsu_wb_t got);
        @(negedge clk);
        while (!wb_valid) @(negedge clk);
        got = wb;
    endtask

    task automatic store_and_check(input mem_op_t op, input xlen_t addr, input xlen_t data);
        lsu_wb_t got;
        send(mem_req(1'b0, op, 4'd0, addr, data));
        collect(got);
        apply_store(op, addr, data);
        check_bit("wb.reg_write", got.reg_write, 1'b0);
        check_word("wb.rd_data", got.rd_data, '0);
        check_strb("w.strb", last_strb, lane_strobe(op, addr));
        check_size("aw.size", aw_size_seen, size_code(op));
        check_word("mem", mem[addr[9:2]], ref_mem[addr[9:2]]);
    endtask

    task automatic load_and_check(input mem_op_t op, input xlen_t addr, input reg_addr_t rd);
        lsu_wb_t got;
        send(mem_req(1'b1, op, rd, addr, '0));
        collect(got);
        check_word("wb.rd_data", got.rd_data, load_value(op, addr));
        check_rd("wb.rd", got.rd, rd);
        check_bit("wb.reg_write", got.reg_write, 1'b1);
        check_size("ar.size", ar_size_seen, size_code(op));
    endtask

    task automatic reset_values();
        @(negedge clk);
        check_bit("ex_ready", ex_ready, 1'b1);
        check_bit("wb_valid", wb_valid, 1'b0);
        check_bit("ar_valid", ar_valid, 1'b0);
        check_bit("aw_valid", aw_valid, 1'b0);
        check_bit("w_valid", w_valid, 1'b0);
        check_bit("r_ready", r_ready, 1'b0);
        check_rd("fwd_rd", fwd_rd, 4'd0);
        check_bit("fwd_reg_write", fwd_reg_write, 1'b0);
        check_bit("fwd_is_load", fwd_is_load, 1'b0);
    endtask

    task automatic alu_passthrough();
        lsu_req_t req;
        req           = '0;
        req.reg_write = 1'b1;
        req.rd        = 4'd5;
        req.addr      = 32'h0000_0044;
        req.result    = 32'h1234_5678;
        send(req);
        @(negedge clk);                 // first cycle after acceptance
        check_bit("wb_valid", wb_valid, 1'b1);
        check_word("wb.rd_data", wb.rd_data, 32'h1234_5678);
        check_rd("wb.rd", wb.rd, 4'd5);
        check_bit("wb.reg_write", wb.reg_write, 1'b1);
        check_rd("fwd_rd", fwd_rd, 4'd5);
        check_bit("ar_valid", ar_valid, 1'b0);
        @(negedge clk);
        check_bit("wb_valid", wb_valid, 1'b0);
        check_bit("fwd_reg_write", fwd_reg_write, 1'b0);
    endtask

    task automatic word_round_trip();
        store_and_check(MEM_W, 32'h0000_0040, 32'hdead_beef);
        load_and_check(MEM_W, 32'h0000_0040, 4'd3);
    endtask

    task automatic sub_word_lanes();
        for (int off = 0; off < 4; off++) begin
            store_and_check(MEM_B, 32'h80 + off, 32'h1234_567f + off); // 7f then negative bytes
        end
        for (int off = 0; off < 4; off++) begin
            load_and_check(MEM_B, 32'h80 + off, 4'd1);
            load_and_check(MEM_BU, 32'h80 + off, 4'd2);
        end
        store_and_check(MEM_H, 32'h0000_00c0, 32'h0000_8001);
        store_and_check(MEM_HU, 32'h0000_00c2, 32'hffff_7ffe);
        for (int off = 0; off < 4; off += 2) begin
            load_and_check(MEM_H, 32'hc0 + off, 4'd4);
            load_and_check(MEM_HU, 32'hc0 + off, 4'd6);
            load_and_check(MEM_B, 32'hc1 + off, 4'd7);
        end
        load_and_check(MEM_W, 32'h0000_00c0, 4'd8);
    endtask

    task automatic wb_stall();
        lsu_wb_t got;
        xlen_t   exp;
        exp = load_value(MEM_H, 32'h0000_00c2);
        @(posedge clk);
        #1;
        wb_ready = 1'b0;
        send(mem_req(1'b1, MEM_H, 4'd9, 32'h0000_00c2, '0));
        @(negedge clk);
        check_bit("fwd_is_load", fwd_is_load, 1'b1);
        check_rd("fwd_rd", fwd_rd, 4'd9);
        collect(got);
        check_word("wb.rd_data", got.rd_data, exp);
        repeat (4) begin
            @(negedge clk);
            check_bit("wb_valid", wb_valid, 1'b1);
            check_bit("ex_ready", ex_ready, 1'b0);
            check_bit("fwd_is_load", fwd_is_load, 1'b1);
            check_rd("fwd_rd", fwd_rd, 4'd9);
            check_rd("wb.rd", wb.rd, 4'd9);
            check_word("wb.rd_data", wb.rd_data, exp);
        end
        @(posedge clk);
        #1;
        wb_ready = 1'b1;
        repeat (2) @(negedge clk);      // handshake edge in between
        check_bit("wb_valid", wb_valid, 1'b0);
        check_bit("fwd_is_load", fwd_is_load, 1'b0);
        check_rd("fwd_rd", fwd_rd, 4'd0);
    endtask

    task automatic random_traffic(input int n);
        mem_op_t ops [5] = '{MEM_B, MEM_BU, MEM_H, MEM_HU, MEM_W};
        integer  r;
        xlen_t   data;
        xlen_t   addr;
        mem_op_t op;
        for (int i = 0; i < n; i++) begin
            r    = $random(seed);
            data = $random(seed);
            op   = ops[int'(r[7:0]) % 5];
            addr = {22'h0, 4'h0, r[11:8], r[13:12]}; // 16 words for frequent reuse
            if (op_bytes(op) == 2) addr[0] = 1'b0;
            if (op_bytes(op) == 4) addr[1:0] = 2'b00;
            if (r[16]) begin
                store_and_check(op, addr, data);
            end else begin
                load_and_check(op, addr, r[23:20]);
            end
        end
    endtask

    // axi slave with one-cycle ready pulses after a random delay
    initial begin : axi_slave
        logic [1:0] ar_wait, r_wait, aw_wait, w_wait, b_wait;
        logic       rd_pend, aw_got, w_got;
        xlen_t      rd_addr, wr_addr;
        axi_w_t     wr_w;
        for (int i = 0; i < 256; i++) mem[i] = fill_word(i);
        {ar_ready, r_valid, aw_ready, w_ready, b_valid} = '0;
        r_data = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rst) begin
                {ar_ready, r_valid, aw_ready, w_ready, b_valid} = '0;
                {rd_pend, aw_got, w_got} = '0;
                ar_wait = rand_delay();
                r_wait  = rand_delay();
                aw_wait = rand_delay();
                w_wait  = rand_delay();
                b_wait  = rand_delay();
            end else begin
                if (ar_ready) begin
                    ar_ready     = 1'b0;
                    rd_addr      = ar.addr;
                    ar_size_seen = ar.size;
                    rd_pend      = 1'b1;
                end else if (ar_valid) begin
                    ar_ready = expired(ar_wait);
                end
                if (r_valid) begin
                    r_valid = 1'b0;
                end else if (rd_pend) begin
                    r_valid = expired(r_wait);
                    rd_pend = !r_valid;
                    r_data  = mem[rd_addr[9:2]];
                    if (r_valid) begin
                        check_bit("r_ready", r_ready, 1'b1); // high throughout the read
                    end
                end
                if (aw_ready) begin
                    aw_ready     = 1'b0;
                    aw_got       = 1'b1;
                    wr_addr      = aw.addr;
                    aw_size_seen = aw.size;
                end else if (aw_valid) begin
                    aw_ready = expired(aw_wait);
                end
                if (w_ready) begin
                    w_ready = 1'b0;
                    w_got   = 1'b1;
                    wr_w    = w;
                end else if (w_valid) begin
                    w_ready = expired(w_wait);
                end
                if (b_valid) begin
                    b_valid = 1'b0;
                end else if (aw_got && w_got) begin
                    b_valid = expired(b_wait);
                    if (b_valid) begin
                        for (int b = 0; b < 4; b++) begin
                            if (wr_w.strb[b]) mem[wr_addr[9:2]][8*b +: 8] = wr_w.data[8*b +: 8];
                        end
                        last_strb = wr_w.strb;
                        aw_got    = 1'b0;
                        w_got     = 1'b0;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin : main
        for (int i = 0; i < 256; i++) ref_mem[i] = fill_word(i);
        rst      = 1'b1;
        ex_valid = 1'b0;
        ex_req   = '0;
        wb_ready = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_values();
        alu_passthrough();
        word_round_trip();
        sub_word_lanes();
        wb_stall();
        random_traffic(40);
        $display("%0d errors in %0d checks", n_errors, n_checks);
        if (n_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: tests/lsu_asserts.sv
`timescale 1ns/1ps

module lsu_asserts (
    input logic             clk,
    input logic             rst,
    input logic             ar_valid,
    input logic             ar_ready,
    input logic             aw_valid,
    input logic             aw_ready,
    input logic             wb_valid,
    input logic             wb_ready,
    input lsu_pkg::lsu_wb_t wb
);

    // address valids held until accepted
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        (ar_valid && !ar_ready) |=> ar_valid)
        else $error("ar_valid dropped before ar_ready");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        (aw_valid && !aw_ready) |=> aw_valid)
        else $error("aw_valid dropped before aw_ready");

    rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(ar_valid && aw_valid))
        else $error("ar_valid and aw_valid high together");

    wb_stable: assert property (@(posedge clk) disable iff (rst)
        (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb)))
        else $error("writeback changed while stalled");

endmodule

bind lsu_stage lsu_asserts i_lsu_asserts (
    .clk      (clk),
    .rst      (rst),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .wb_valid (wb_valid),
    .wb_ready (wb_ready),
    .wb       (wb)
);

// File: design/lsu_stage.sv
`timescale 1ns/1ps

module lsu_stage (
    input  logic                clk,
    input  logic                rst,

    // execute side
    input  logic                ex_valid,
    input  lsu_pkg::lsu_req_t   ex_req,
    output logic                ex_ready,

    // writeback side
    output logic                wb_valid,
    output lsu_pkg::lsu_wb_t    wb,
    input  logic                wb_ready,

    // hazard forwarding
    output lsu_pkg::reg_addr_t  fwd_rd,
    output logic                fwd_reg_write,
    output logic                fwd_is_load,

    // axi read
    output logic                ar_valid,
    input  logic                ar_ready,
    output lsu_pkg::axi_ar_t    ar,
    input  logic                r_valid,
    input  lsu_pkg::xlen_t      r_data,
    output logic                r_ready,

    // axi write
    output logic                aw_valid,
    input  logic                aw_ready,
    output lsu_pkg::axi_aw_t    aw,
    output logic                w_valid,
    input  logic                w_ready,
    output lsu_pkg::axi_w_t     w,
    input  logic                b_valid
);
    import lsu_pkg::*;

    lsu_req_t  req_q;
    logic      busy;      // axi access outstanding
    logic      held;      // instruction in stage until wb handshake
    logic      accept;
    logic      is_mem;

    xlen_t     st_wdata;
    strb_t     st_wstrb;
    axi_size_t st_size;
    logic      mem_done;
    xlen_t     mem_rdata;
    xlen_t     load_data;

    assign is_mem   = ex_req.mem_read || ex_req.mem_write;
    assign ex_ready = !busy && (!wb_valid || wb_ready);
    assign accept   = ex_valid && ex_ready;

    assign fwd_rd        = held ? req_q.rd : '0;
    assign fwd_reg_write = held && req_q.reg_write;
    assign fwd_is_load   = held && req_q.mem_read;

    lsu_store_align i_store_align (
        .mem_op     (req_q.mem_op),
        .addr       (req_q.addr),
        .store_data (req_q.store_data),
        .wdata      (st_wdata),
        .wstrb      (st_wstrb),
        .size       (st_size)
    );

    // started from the live request, payload read from req_q afterwards
    lsu_axi_master i_axi_master (
        .clk      (clk),
        .rst      (rst),
        .start    (accept && is_mem),
        .is_write (ex_req.mem_write),
        .addr     (req_q.addr),
        .size     (st_size),
        .wdata    (st_wdata),
        .wstrb    (st_wstrb),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .r_valid  (r_valid),
        .r_data   (r_data),
        .r_ready  (r_ready),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw       (aw),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w        (w),
        .b_valid  (b_valid),
        .done     (mem_done),
        .rdata    (mem_rdata)
    );

    lsu_load_extract i_load_extract (
        .mem_op    (req_q.mem_op),
        .offset    (req_q.addr[1:0]),
        .rdata     (mem_rdata),
        .load_data (load_data)
    );

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= ex_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            held     <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            if (accept && is_mem) begin
                busy <= 1'b1;
            end else if (mem_done) begin
                busy <= 1'b0;
            end

            if (accept) begin
                held <= 1'b1;
            end else if (wb_valid && wb_ready) begin
                held <= 1'b0;
            end

            if ((accept && !is_mem) || mem_done) begin
                wb_valid <= 1'b1;
            end else if (wb_ready) begin
                wb_valid <= 1'b0;
            end
        end
    end

    // writeback payload
    always_ff @(posedge clk) begin
        if (accept && !is_mem) begin
            wb.reg_write <= ex_req.reg_write;
            wb.rd        <= ex_req.rd;
            wb.rd_data   <= ex_req.result;
        end else if (mem_done) begin
            wb.reg_write <= req_q.reg_write;
            wb.rd        <= req_q.rd;
            wb.rd_data   <= req_q.mem_read ? load_data : '0; // stores write back zero
        end
    end

endmodule

// File: design/lsu_axi_master.sv
`timescale 1ns/1ps

module lsu_axi_master (
    input  logic               clk,
    input  logic               rst,

    // request from the stage
    input  logic               start,
    input  logic               is_write,
    input  lsu_pkg::xlen_t     addr,
    input  lsu_pkg::axi_size_t size,
    input  lsu_pkg::xlen_t     wdata,
    input  lsu_pkg::strb_t     wstrb,

    // read address / data
    output logic               ar_valid,
    input  logic               ar_ready,
    output lsu_pkg::axi_ar_t   ar,
    input  logic               r_valid,
    input  lsu_pkg::xlen_t     r_data,
    output logic               r_ready,

    // write address / data / response
    output logic               aw_valid,
    input  logic               aw_ready,
    output lsu_pkg::axi_aw_t   aw,
    output logic               w_valid,
    input  logic               w_ready,
    output lsu_pkg::axi_w_t    w,
    input  logic               b_valid,

    output logic               done,
    output lsu_pkg::xlen_t     rdata
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RD,
        WR
    } state_t;

    state_t state;

    logic aw_done;
    logic w_done;
    logic b_done;
    logic aw_hs;
    logic w_hs;
    logic rd_finish;
    logic wr_finish;

    // payload comes straight from the held request
    assign ar = '{addr: addr, size: size};
    assign aw = '{addr: addr, size: size};
    assign w  = '{data: wdata, strb: wstrb};

    assign r_ready = (state == RD);

    assign aw_hs = aw_valid && aw_ready;
    assign w_hs  = w_valid && w_ready;

    assign rd_finish = (state == RD) && r_valid;
    // channels may complete in any order, count a handshake in this cycle too
    assign wr_finish = (state == WR)
                     && (aw_done || aw_hs)
                     && (w_done || w_hs)
                     && (b_done || b_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            ar_valid <= 1'b0;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
            b_done   <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    b_done  <= 1'b0;
                    if (start) begin
                        if (is_write) begin
                            state    <= WR;
                            aw_valid <= 1'b1; // aw and w go out together
                            w_valid  <= 1'b1;
                        end else begin
                            state    <= RD;
                            ar_valid <= 1'b1;
                        end
                    end
                end
                RD: begin
                    if (ar_valid && ar_ready) begin
                        ar_valid <= 1'b0;
                    end
                    if (rd_finish) begin
                        state    <= IDLE;
                        ar_valid <= 1'b0;
                        done     <= 1'b1;
                    end
                end
                WR: begin
                    if (aw_hs) begin
                        aw_valid <= 1'b0;
                        aw_done  <= 1'b1;
                    end
                    if (w_hs) begin
                        w_valid <= 1'b0;
                        w_done  <= 1'b1;
                    end
                    if (b_valid) begin
                        b_done <= 1'b1;   // bready tied high at the slave
                    end
                    if (wr_finish) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // read word, valid alongside done
    always_ff @(posedge clk) begin
        if (rd_finish) begin
            rdata <= r_data;
        end
    end

endmodule

// File: design/lsu_load_extract.sv
`timescale 1ns/1ps

module lsu_load_extract (
    input  lsu_pkg::mem_op_t mem_op,
    input  logic [1:0]       offset,
    input  lsu_pkg::xlen_t   rdata,
    output lsu_pkg::xlen_t   load_data
);
    import lsu_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // pick the addressed lane
    always_comb begin
        case (offset)
            2'd0:    byte_sel = rdata[7:0];
            2'd1:    byte_sel = rdata[15:8];
            2'd2:    byte_sel = rdata[23:16];
            default: byte_sel = rdata[31:24];
        endcase
    end

    assign half_sel = offset[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (mem_op)
            MEM_B: begin
                load_data = {{24{byte_sel[7]}}, byte_sel};
            end
            MEM_BU: begin
                load_data = {24'h0, byte_sel};
            end
            MEM_H: begin
                load_data = {{16{half_sel[15]}}, half_sel};
            end
            MEM_HU: begin
                load_data = {16'h0, half_sel};
            end
            default: load_data = rdata; // full word
        endcase
    end

endmodule

// File: design/lsu_store_align.sv
`timescale 1ns/1ps

module lsu_store_align (
    input  lsu_pkg::mem_op_t   mem_op,
    input  lsu_pkg::xlen_t     addr,
    input  lsu_pkg::xlen_t     store_data,
    output lsu_pkg::xlen_t     wdata,
    output lsu_pkg::strb_t     wstrb,
    output lsu_pkg::axi_size_t size
);
    import lsu_pkg::*;

    logic [1:0] offset;

    assign offset = addr[1:0];

    always_comb begin
        case (mem_op)
            MEM_B, MEM_BU: begin
                // byte lands on its own lane
                wdata = {24'h0, store_data[7:0]} << {offset, 3'b000};
                wstrb = 4'b0001 << offset;
                size  = AXI_SIZE_BYTE;
            end
            MEM_H, MEM_HU: begin
                if (offset[1]) begin
                    wdata = {store_data[15:0], 16'h0};
                    wstrb = 4'b1100;
                end else begin
                    wdata = {16'h0, store_data[15:0]};
                    wstrb = 4'b0011;
                end
                size = AXI_SIZE_HALF;
            end
            default: begin // word, also MEM_NONE
                wdata = store_data;
                wstrb = 4'b1111;
                size  = AXI_SIZE_WORD;
            end
        endcase
    end

endmodule

// File: design/lsu_pkg.sv
package lsu_pkg;

    // rv32 data path, rv32e register file
    typedef logic [31:0] xlen_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [3:0]  strb_t;
    typedef logic [2:0]  axi_size_t;

    // axsize encodings
    localparam axi_size_t AXI_SIZE_BYTE = 3'h0;
    localparam axi_size_t AXI_SIZE_HALF = 3'h1;
    localparam axi_size_t AXI_SIZE_WORD = 3'h2;

    // access width and signedness of a load or store
    typedef enum logic [2:0] {
        MEM_NONE = 3'd0,
        MEM_B    = 3'd1,
        MEM_BU   = 3'd2,
        MEM_H    = 3'd3,
        MEM_HU   = 3'd4,
        MEM_W    = 3'd5
    } mem_op_t;

    // request from execute
    typedef struct packed {
        logic      mem_read;
        logic      mem_write;
        mem_op_t   mem_op;
        logic      reg_write;
        reg_addr_t rd;
        xlen_t     addr;
        xlen_t     store_data;
        xlen_t     result;     // alu result, used by non-memory ops
    } lsu_req_t;

    // read address channel payload
    typedef struct packed {
        xlen_t     addr;
        axi_size_t size;
    } axi_ar_t;

    // write address channel payload
    typedef struct packed {
        xlen_t     addr;
        axi_size_t size;
    } axi_aw_t;

    // write data channel payload
    typedef struct packed {
        xlen_t data;
        strb_t strb;
    } axi_w_t;

    // to writeback
    typedef struct packed {
        logic      reg_write;
        reg_addr_t rd;
        xlen_t     rd_data;
    } lsu_wb_t;

endpackage
